//--- src/wavegen_config.svh
// Wave generator configuration
`ifndef WAVEGEN_CONFIG_SVH
`define WAVEGEN_CONFIG_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

`define WG_LEVEL_W     8    // DAC level and operand width
`define WG_PROG_DEPTH  8    // Instructions per axis
`define WG_PTR_W       3    // Program pointer width

//////////////////////////////////////////////////
// Wishbone port and register map
//////////////////////////////////////////////////

`define WG_WB_ADR_W    5    // Word address
`define WG_WB_DAT_W    32

`define WG_ADDR_CTRL   5'd0     // Control word, bit 0 is run
`define WG_ADDR_XPROG  5'd16    // X program, words 16 to 23
`define WG_ADDR_YPROG  5'd24    // Y program, words 24 to 31

`endif

//--- src/wavegen_pkg.sv
// Wave generator types
`include "wavegen_config.svh"

package wavegen_pkg;

    //////////////////////////////////////////////////
    // Instruction set
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        NOP    = 3'd0,  // Hold one cycle
        LINE   = 3'd1,  // Load a, ramp to b
        INCR   = 3'd2,
        DECR   = 3'd3,
        JUMP   = 3'd4,  // Level becomes a
        X_RECT = 3'd5,  // Up a, hold b, down a, hold b
        Y_RECT = 3'd6   // Hold a, up b, hold a, down b
    } opcode_e;

    // Opcode in the top bits, then operand a, then operand b
    typedef struct packed {
        opcode_e                op;
        logic [`WG_LEVEL_W-1:0] a;
        logic [`WG_LEVEL_W-1:0] b;
    } instr_t;

    //////////////////////////////////////////////////
    // Sequencer state
    //////////////////////////////////////////////////

    // FETCH is the first cycle of every instruction
    typedef enum logic [2:0] {
        FETCH,
        P0,
        P1,
        P2,
        P3
    } phase_e;

    typedef enum logic [1:0] {
        HOLD,
        UP,
        DOWN
    } step_e;

endpackage

//--- src/prog_if.sv
// Program fetch interface
`include "wavegen_config.svh"

interface prog_if
    import wavegen_pkg::*;
();

    logic                 run;        // Control register run bit
    instr_t               instr;      // Memory entry at fetch_ptr, no clock
    logic [`WG_PTR_W-1:0] fetch_ptr;  // Sequencer program pointer

    // Register block side
    modport regs (
        output run,
        output instr,
        input  fetch_ptr
    );

    // Sequencer side
    modport seq (
        input  run,
        input  instr,
        output fetch_ptr
    );

endinterface

//--- src/program_regs.sv
// Wishbone program registers
`include "wavegen_config.svh"

module program_regs
    import wavegen_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`WG_WB_ADR_W-1:0] wb_adr,
    input  logic [`WG_WB_DAT_W-1:0] wb_dat_w,
    output logic [`WG_WB_DAT_W-1:0] wb_dat_r,
    output logic                    wb_ack,
    prog_if.regs                    x_prog,
    prog_if.regs                    y_prog
);

    localparam int     INSTR_W   = $bits(instr_t);
    localparam instr_t NOP_INSTR = '{op: NOP, a: '0, b: '0};

    logic                    run;
    instr_t                  x_mem [`WG_PROG_DEPTH];
    instr_t                  y_mem [`WG_PROG_DEPTH];
    logic                    accept;
    logic [`WG_WB_ADR_W-1:0] base;
    logic [`WG_PTR_W-1:0]    idx;
    logic                    ctrl_hit;
    logic                    x_hit;
    logic                    y_hit;
    instr_t                  new_instr;
    logic [`WG_WB_DAT_W-1:0] rd_data;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    // New request only when no ack is pending, so a held strobe waits a cycle
    assign accept = wb_cyc && wb_stb && !wb_ack;

    assign base     = {wb_adr[`WG_WB_ADR_W-1:`WG_PTR_W], {`WG_PTR_W{1'b0}}};
    assign idx      = wb_adr[`WG_PTR_W-1:0];    // Entry within a program
    assign ctrl_hit = (wb_adr == `WG_ADDR_CTRL);
    assign x_hit    = (base == `WG_ADDR_XPROG);
    assign y_hit    = (base == `WG_ADDR_YPROG);

    assign new_instr = instr_t'(wb_dat_w[INSTR_W-1:0]);

    //////////////////////////////////////////////////
    // Control register and program memories
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
            for (int i = 0; i < `WG_PROG_DEPTH; i++) begin
                x_mem[i] <= NOP_INSTR;
                y_mem[i] <= NOP_INSTR;
            end
        end else if (accept && wb_we) begin
            if (ctrl_hit) begin
                run <= wb_dat_w[0];
            end
            if (x_hit) begin
                x_mem[idx] <= new_instr;
            end
            if (y_hit) begin
                y_mem[idx] <= new_instr;
            end
        end
    end

    // Unmapped words read as zero
    always_comb begin
        rd_data = '0;
        if (ctrl_hit) begin
            rd_data[0] = run;
        end else if (x_hit) begin
            rd_data[INSTR_W-1:0] = x_mem[idx];
        end else if (y_hit) begin
            rd_data[INSTR_W-1:0] = y_mem[idx];
        end
    end

    //////////////////////////////////////////////////
    // Bus acknowledge
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= accept;   // One clock, then low for at least one
        end
    end

    // Read data only has to be valid while wb_ack is high
    always_ff @(posedge clk) begin
        if (accept) begin
            wb_dat_r <= rd_data;
        end
    end

    // Fetch ports, read straight from the arrays
    assign x_prog.run   = run;
    assign x_prog.instr = x_mem[x_prog.fetch_ptr];
    assign y_prog.run   = run;
    assign y_prog.instr = y_mem[y_prog.fetch_ptr];

endmodule

//--- src/wave_sequencer.sv
// Per-axis waveform sequencer
`include "wavegen_config.svh"

module wave_sequencer
    import wavegen_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    prog_if.seq                    prog,
    output logic [`WG_LEVEL_W-1:0] level
);

    logic [`WG_PTR_W-1:0]   ptr;
    phase_e                 phase;
    logic [`WG_LEVEL_W-1:0] cnt;        // Cycles done in the current phase

    instr_t                 held_instr; // Copy taken at fetch
    instr_t                 cur_instr;
    phase_e                 cur_ph;
    logic [`WG_LEVEL_W-1:0] cur_cnt;
    logic [`WG_LEVEL_W-1:0] op_a;
    logic [`WG_LEVEL_W-1:0] op_b;

    step_e                  step;
    step_e                  dir;
    logic [`WG_LEVEL_W-1:0] len;        // Phase length, 0 means one hold cycle
    logic                   load;       // Level takes operand a
    logic                   last;       // Final phase of the instruction
    logic                   phase_end;

    //////////////////////////////////////////////////
    // Current instruction and phase
    //////////////////////////////////////////////////

    // FETCH runs the first cycle of phase P0 straight from memory
    assign cur_instr = (phase == FETCH) ? prog.instr : held_instr;
    assign cur_ph    = (phase == FETCH) ? P0 : phase;
    assign cur_cnt   = (phase == FETCH) ? '0 : cnt;

    assign op_a = cur_instr.a;
    assign op_b = cur_instr.b;

    // A word rewritten mid-instruction only counts at its next fetch
    always_ff @(posedge clk) begin
        held_instr <= cur_instr;
    end

    assign prog.fetch_ptr = ptr;

    //////////////////////////////////////////////////
    // Phase decode
    //////////////////////////////////////////////////

    always_comb begin
        step = HOLD;
        len  = '0;
        load = 1'b0;
        last = 1'b1;

        case (cur_instr.op)
            JUMP: begin
                load = 1'b1;
            end
            LINE: begin
                if (cur_ph == P0) begin
                    load = 1'b1;                // Load cycle
                    last = (op_a == op_b);      // No ramp when already there
                end else if (op_b > op_a) begin
                    step = UP;
                    len  = op_b - op_a;
                end else begin
                    step = DOWN;
                    len  = op_a - op_b;
                end
            end
            INCR: begin
                step = UP;
                len  = op_a;
            end
            DECR: begin
                step = DOWN;
                len  = op_a;
            end
            X_RECT: begin
                last = (cur_ph == P3);
                case (cur_ph)
                    P0: begin
                        step = UP;
                        len  = op_a;
                    end
                    P2: begin
                        step = DOWN;
                        len  = op_a;
                    end
                    default: len = op_b;    // Both hold phases
                endcase
            end
            Y_RECT: begin
                last = (cur_ph == P3);
                case (cur_ph)
                    P1: begin
                        step = UP;
                        len  = op_b;
                    end
                    P3: begin
                        step = DOWN;
                        len  = op_b;
                    end
                    default: len = op_a;
                endcase
            end
            default: ;  // NOP and unused codes hold one cycle
        endcase
    end

    // Zero length phases hold for their single cycle
    assign dir       = (len == '0) ? HOLD : step;
    assign phase_end = (len == '0) || (cur_cnt == len - 1'b1);

    //////////////////////////////////////////////////
    // State and level update
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || !prog.run) begin
            ptr   <= '0;
            phase <= FETCH;
            cnt   <= '0;
            level <= '0;
        end else begin
            if (load) begin
                level <= op_a;
            end else begin
                case (dir)
                    UP:      level <= level + 1'b1;    // Wraps at 255
                    DOWN:    level <= level - 1'b1;
                    default: level <= level;
                endcase
            end

            if (!phase_end) begin
                cnt   <= cur_cnt + 1'b1;
                phase <= cur_ph;
            end else if (last) begin
                // Next entry starts on the following edge
                cnt   <= '0;
                phase <= FETCH;
                ptr   <= ptr + 1'b1;
            end else begin
                cnt   <= '0;
                phase <= phase_e'(cur_ph + 3'd1);
            end
        end
    end

endmodule

//--- src/wavegen_top.sv
// Vector waveform generator top
`include "wavegen_config.svh"

module wavegen_top (
    input  logic                    clk,
    input  logic                    reset,

    // Wishbone classic slave
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`WG_WB_ADR_W-1:0] wb_adr,
    input  logic [`WG_WB_DAT_W-1:0] wb_dat_w,
    output logic [`WG_WB_DAT_W-1:0] wb_dat_r,
    output logic                    wb_ack,

    // DAC levels
    output logic [`WG_LEVEL_W-1:0]  dac_x,
    output logic [`WG_LEVEL_W-1:0]  dac_y
);

    prog_if x_prog_bus ();
    prog_if y_prog_bus ();

    //////////////////////////////////////////////////
    // Register block
    //////////////////////////////////////////////////

    program_regs prog_regs (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .x_prog   (x_prog_bus.regs),
        .y_prog   (y_prog_bus.regs)
    );

    //////////////////////////////////////////////////
    // Axis sequencers
    //////////////////////////////////////////////////

    wave_sequencer x_seq (
        .clk   (clk),
        .reset (reset),
        .prog  (x_prog_bus.seq),
        .level (dac_x)
    );

    wave_sequencer y_seq (
        .clk   (clk),
        .reset (reset),
        .prog  (y_prog_bus.seq),
        .level (dac_y)
    );

endmodule

//--- tb/wavegen_checker.sv
// Wave generator result checker
`include "wavegen_config.svh"

module wavegen_checker (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`WG_WB_ADR_W-1:0] wb_adr,
    input  logic [`WG_WB_DAT_W-1:0] wb_dat_r,
    input  logic                    wb_ack,
    input  logic [`WG_LEVEL_W-1:0]  dac_x,
    input  logic [`WG_LEVEL_W-1:0]  dac_y,
    input  logic                    rd_check,     // Compare read data at the ack
    input  logic [`WG_WB_DAT_W-1:0] rd_exp,
    input  logic                    level_check,  // Compare DAC levels on this edge
    input  int                      exp_offset,
    input  logic [`WG_LEVEL_W-1:0]  exp_x,
    input  logic [`WG_LEVEL_W-1:0]  exp_y,
    output int                      edge_cnt,     // Edges since the last control write ack
    output int                      checks,
    output int                      errors
);

    int   ack_wait;
    logic ack_prev;

    initial begin
        checks   = 0;
        errors   = 0;
        ack_wait = 0;
        ack_prev = 1'b0;
    end

    //////////////////////////////////////////////////
    // Everything here sees the values from before the edge
    always @(posedge clk) begin
        if (reset) begin
            edge_cnt <= 0;
        end else if (wb_ack && wb_we && wb_adr == `WG_ADDR_CTRL) begin
            edge_cnt <= 1;  // First program cycle runs on this edge
        end else if (edge_cnt != 0) begin
            edge_cnt <= edge_cnt + 1;
        end

        if (!reset && wb_cyc && wb_stb && !wb_ack) begin
            ack_wait++;
            if (ack_wait == 4) begin
                $display("no ack within 4 cycles for word %0d at time %0t", wb_adr, $time);
                errors++;
            end
        end else begin
            ack_wait = 0;
        end

        // Ack is one clock wide, never back to back
        if (wb_ack && ack_prev) begin
            $display("ack stayed high for more than one clock at time %0t", $time);
            errors++;
        end
        ack_prev = wb_ack;

        if (wb_ack && rd_check && !wb_we) begin
            checks++;
            if (wb_dat_r !== rd_exp) begin
                $display("mismatch at time %0t: word %0d read %h, expected %h",
                         $time, wb_adr, wb_dat_r, rd_exp);
                errors++;
            end
        end

        if (level_check) begin
            checks++;
            if (edge_cnt != exp_offset) begin
                $display("level check ran at offset %0d instead of %0d", edge_cnt, exp_offset);
                errors++;
            end else if (dac_x !== exp_x || dac_y !== exp_y) begin
                $display("mismatch at time %0t: offset %0d dac_x %0d dac_y %0d, expected %0d %0d",
                         $time, edge_cnt, dac_x, dac_y, exp_x, exp_y);
                errors++;
            end
        end
    end

endmodule

//--- tb/tb_wavegen.sv
// Wave generator testbench
`include "wavegen_config.svh"

module tb_wavegen
    import wavegen_pkg::*;
();

    typedef enum {K_WRITE, K_READ, K_RUN, K_SAMPLE} kind_e;

    typedef struct {
        kind_e                   kind;
        logic [`WG_WB_ADR_W-1:0] adr;
        logic [`WG_WB_DAT_W-1:0] data;      // Write data or expected read data
        int                      offset;    // Edges after the run ack
        logic [`WG_LEVEL_W-1:0]  x;
        logic [`WG_LEVEL_W-1:0]  y;
    } row_t;

    logic                    clk, reset;
    logic                    wb_cyc, wb_stb, wb_we, wb_ack;
    logic [`WG_WB_ADR_W-1:0] wb_adr;
    logic [`WG_WB_DAT_W-1:0] wb_dat_w, wb_dat_r, rd_exp;
    logic [`WG_LEVEL_W-1:0]  dac_x, dac_y, exp_x, exp_y;
    logic                    rd_check, level_check;
    int                      exp_offset, edge_cnt, checks, errors;
    int                      cycles, cycle_limit;
    row_t                    stim_rows[$];

    wavegen_top dut_i (.*);

    wavegen_checker check_i (.*);

    always #4 clk = ~clk;

    // Run limit from the table
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, table not finished", cycles);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [`WG_WB_DAT_W-1:0] instr_word(opcode_e op,
            logic [`WG_LEVEL_W-1:0] a, logic [`WG_LEVEL_W-1:0] b);
        return {13'd0, op, a, b};   // Opcode 18:16, a 15:8, b 7:0
    endfunction

    function automatic void add_row(kind_e kind, int adr, logic [`WG_WB_DAT_W-1:0] data,
            int offset = 0, int x = 0, int y = 0);
        row_t r;
        r.kind   = kind;
        r.adr    = adr;
        r.data   = data;
        r.offset = offset;
        r.x      = x;
        r.y      = y;
        stim_rows.push_back(r);
    endfunction

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    function automatic void build_table();
        // Reset state
        add_row(K_SAMPLE, 0, 0, 0, 0, 0);
        add_row(K_READ, `WG_ADDR_CTRL, 0);
        for (int a = `WG_ADDR_XPROG; a < 32; a++) begin
            add_row(K_READ, a, 0);
        end
        add_row(K_WRITE, 17, 32'h0005_A5C3);
        add_row(K_READ, 17, 32'h0005_A5C3);
        add_row(K_WRITE, 30, 32'hFFFF_FFFF);
        add_row(K_READ, 30, 32'h0007_FFFF);     // Only 19 bits kept
        add_row(K_WRITE, 30, 0);
        add_row(K_WRITE, 5, 32'h0000_1234);     // Unmapped word
        add_row(K_READ, 5, 0);
        // JUMP, INCR, DECR, then five NOPs
        add_row(K_WRITE, 16, instr_word(JUMP, 10, 0));
        add_row(K_WRITE, 17, instr_word(INCR, 5, 0));
        add_row(K_WRITE, 18, instr_word(DECR, 3, 0));
        add_row(K_RUN, 0, 1);
        add_row(K_SAMPLE, 0, 0, 1, 10, 0);
        add_row(K_SAMPLE, 0, 0, 6, 15, 0);
        add_row(K_SAMPLE, 0, 0, 9, 12, 0);
        add_row(K_SAMPLE, 0, 0, 14, 12, 0);
        add_row(K_SAMPLE, 0, 0, 15, 10, 0);     // Pointer wrapped to JUMP
        // Stop, then restart from entry 0
        add_row(K_RUN, 0, 0);
        add_row(K_SAMPLE, 0, 0, 1, 0, 0);
        add_row(K_RUN, 0, 1);
        add_row(K_SAMPLE, 0, 0, 1, 10, 0);
        add_row(K_RUN, 0, 0);
        // LINE up then down
        add_row(K_WRITE, 16, instr_word(LINE, 20, 24));
        add_row(K_WRITE, 17, instr_word(LINE, 30, 27));
        add_row(K_WRITE, 18, instr_word(NOP, 0, 0));
        add_row(K_RUN, 0, 1);
        add_row(K_SAMPLE, 0, 0, 1, 20, 0);
        add_row(K_SAMPLE, 0, 0, 5, 24, 0);
        add_row(K_SAMPLE, 0, 0, 6, 30, 0);
        add_row(K_SAMPLE, 0, 0, 9, 27, 0);
        add_row(K_RUN, 0, 0);
        // Rectangles on both axes from level 50
        add_row(K_WRITE, 16, instr_word(JUMP, 50, 0));
        add_row(K_WRITE, 17, instr_word(X_RECT, 3, 2));
        add_row(K_WRITE, 24, instr_word(JUMP, 50, 0));
        add_row(K_WRITE, 25, instr_word(Y_RECT, 3, 2));
        add_row(K_RUN, 0, 1);
        add_row(K_SAMPLE, 0, 0, 4, 53, 50);
        add_row(K_SAMPLE, 0, 0, 6, 53, 52);
        add_row(K_SAMPLE, 0, 0, 9, 50, 52);
        add_row(K_SAMPLE, 0, 0, 11, 50, 50);
        add_row(K_READ, `WG_ADDR_CTRL, 1);
        add_row(K_RUN, 0, 0);
        add_row(K_SAMPLE, 0, 0, 1, 0, 0);       // Both axes leave 50 for 0
        // Wrap past 255
        add_row(K_WRITE, 16, instr_word(JUMP, 254, 0));
        add_row(K_WRITE, 17, instr_word(INCR, 3, 0));
        add_row(K_RUN, 0, 1);
        add_row(K_SAMPLE, 0, 0, 2, 255, 50);
        add_row(K_SAMPLE, 0, 0, 3, 0, 50);
        add_row(K_SAMPLE, 0, 0, 4, 1, 50);
    endfunction

    //////////////////////////////////////////////////
    // Bus and sample tasks
    //////////////////////////////////////////////////

    task automatic bus_cycle(input logic we, input logic [`WG_WB_ADR_W-1:0] adr,
            input logic [`WG_WB_DAT_W-1:0] data);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = we ? data : '0;
        rd_check = !we;
        rd_exp   = data;
        @(negedge clk);
        while (!wb_ack && waited < 4) begin
            waited++;
            @(negedge clk);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(negedge clk);     // Idle clock while ack is low
    endtask

    task automatic sample_levels(input row_t r);
        while (edge_cnt < r.offset) begin
            @(negedge clk);
        end
        exp_offset  = r.offset;
        exp_x       = r.x;
        exp_y       = r.y;
        level_check = 1'b1;
        @(negedge clk);
        level_check = 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        rd_check    = 1'b0;
        rd_exp      = '0;
        level_check = 1'b0;
        exp_offset  = 0;
        exp_x       = '0;
        exp_y       = '0;
        cycles      = 0;
        build_table();
        cycle_limit = 200;
        foreach (stim_rows[i]) begin
            cycle_limit += stim_rows[i].offset;
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;

        foreach (stim_rows[i]) begin
            case (stim_rows[i].kind)
                K_WRITE:  bus_cycle(1'b1, stim_rows[i].adr, stim_rows[i].data);
                K_READ:   bus_cycle(1'b0, stim_rows[i].adr, stim_rows[i].data);
                K_RUN:    bus_cycle(1'b1, `WG_ADDR_CTRL, stim_rows[i].data);
                default:  sample_levels(stim_rows[i]);
            endcase
        end

        $display("Run finished with %0d checks and %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+src
src/wavegen_pkg.sv
src/prog_if.sv
src/program_regs.sv
src/wave_sequencer.sv
src/wavegen_top.sv
tb/wavegen_checker.sv
tb/tb_wavegen.sv
